// ==== build.f ====
+incdir+source
source/uart_pkg.sv
source/tpu_cmd_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/cmd_decoder.sv
source/mlp_loader.sv
source/resp_serializer.sv
source/tpu_uart_ctrl.sv
dv/tpu_uart_ctrl_sva.sv
dv/tpu_uart_ctrl_tb.sv

// ==== dv/tpu_uart_ctrl_tb.sv ====
`timescale 1ns/1ps

`include "tpu_link_params.svh"

module tpu_uart_ctrl_tb import uart_pkg::*, tpu_cmd_pkg::*;;

    localparam int CLKS     = `TPU_CLKS_PER_BIT;
    localparam int NUM_ROWS = 8;
    localparam int SETTLE   = 12 * CLKS;
    // Up to 12 frames of 10 bits per row plus margin
    localparam longint WATCHDOG_NS = longint'(NUM_ROWS) * 12 * 10 * CLKS * 10 + 20000;

    logic       clk;
    logic       rst;
    logic       uart_rx;
    logic       uart_tx;
    logic       wf_push_col0;
    logic       wf_push_col1;
    byte_t      wf_data_in;
    logic       wf_reset;
    logic       init_act_valid;
    act_word_t  init_act_data;
    logic       start_mlp;
    logic       weights_ready;
    mlp_state_t mlp_state;
    cycle_cnt_t mlp_cycle_cnt;
    acc_t       mlp_acc0;
    acc_t       mlp_acc1;

    // Stimulus table with one command per row
    byte_t      row_cmd       [NUM_ROWS];
    byte_t      row_data      [NUM_ROWS][`TPU_DATA_BYTES];
    mlp_state_t row_state     [NUM_ROWS];
    cycle_cnt_t row_cnt       [NUM_ROWS];
    acc_t       row_acc0      [NUM_ROWS];
    acc_t       row_acc1      [NUM_ROWS];
    int         row_pushes    [NUM_ROWS];
    int         row_acts      [NUM_ROWS];
    int         row_reply_len [NUM_ROWS];

    // Everything the DUT produced in arrival order
    logic       push_col_q  [$];
    byte_t      push_data_q [$];
    act_word_t  act_q       [$];
    byte_t      reply_q     [$];
    int         wf_reset_cnt   = 0;
    int         start_rise_cnt = 0;
    logic       start_prev     = 1'b0;
    int         seed;

    tpu_uart_ctrl tpu_uart_ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .uart_rx        (uart_rx),
        .uart_tx        (uart_tx),
        .wf_push_col0   (wf_push_col0),
        .wf_push_col1   (wf_push_col1),
        .wf_data_in     (wf_data_in),
        .wf_reset       (wf_reset),
        .init_act_valid (init_act_valid),
        .init_act_data  (init_act_data),
        .start_mlp      (start_mlp),
        .weights_ready  (weights_ready),
        .mlp_state      (mlp_state),
        .mlp_cycle_cnt  (mlp_cycle_cnt),
        .mlp_acc0       (mlp_acc0),
        .mlp_acc1       (mlp_acc1)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run();
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h got 0x%h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_act(input string name, input act_word_t exp, input act_word_t act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h got 0x%h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h got 0x%h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic send_serial_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rx = frame[i];
            repeat (CLKS) @(negedge clk);
        end
    endtask

    // Samples each bit near its middle
    task automatic receive_serial_byte(output byte_t b);
        do begin
            @(negedge clk);
        end while (uart_tx !== 1'b0);
        repeat (CLKS / 2) @(negedge clk);
        if (uart_tx !== 1'b0) begin
            $display("Serial monitor saw a start bit that did not last half a bit");
            fail_run();
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS) @(negedge clk);
            b[i] = uart_tx;
        end
        repeat (CLKS) @(negedge clk);
        if (uart_tx !== 1'b1) begin
            $display("Serial monitor saw a low stop bit on uart_tx");
            fail_run();
        end
    endtask

    task automatic fill_row(input int r, input byte_t cmd, input mlp_state_t st,
                            input int pushes, input int acts, input int reply_len);
        row_cmd[r]       = cmd;
        row_state[r]     = st;
        row_cnt[r]       = cycle_cnt_t'($random(seed));
        row_acc0[r]      = $random(seed);
        row_acc1[r]      = $random(seed);
        row_pushes[r]    = pushes;
        row_acts[r]      = acts;
        row_reply_len[r] = reply_len;
        for (int i = 0; i < `TPU_DATA_BYTES; i++) begin
            row_data[r][i] = byte_t'($random(seed));
        end
    endtask

    // MLP model holds idle, then leaves it and expects the request dropped
    task automatic run_execute(input int r);
        int waited;
        while (start_mlp !== 1'b1) begin
            @(negedge clk);
        end
        repeat (8) begin
            @(negedge clk);
            check_flag("start_mlp", 1'b1, start_mlp);
            check_flag("weights_ready", 1'b1, weights_ready);
        end
        mlp_state = row_state[r];
        waited    = 0;
        while (start_mlp || weights_ready) begin
            @(negedge clk);
            waited++;
            if (waited > 2) begin
                $display("start_mlp or weights_ready still high 2 cycles after the MLP left idle");
                fail_run();
            end
        end
    endtask

    task automatic run_row(input int r);
        int    push_base;
        int    act_base;
        int    reply_base;
        int    reset_base;
        int    start_base;
        acc_t  sel_acc;
        byte_t exp_b;
        push_base  = push_col_q.size();
        act_base   = act_q.size();
        reply_base = reply_q.size();
        reset_base = wf_reset_cnt;
        start_base = start_rise_cnt;
        mlp_state     = (row_cmd[r] == EXECUTE) ? MLP_IDLE : row_state[r];
        mlp_cycle_cnt = row_cnt[r];
        mlp_acc0      = row_acc0[r];
        mlp_acc1      = row_acc1[r];

        send_serial_byte(row_cmd[r]);
        if (row_cmd[r] == WRITE_WEIGHT || row_cmd[r] == WRITE_ACT) begin
            for (int i = 0; i < `TPU_DATA_BYTES; i++) begin
                send_serial_byte(row_data[r][i]);
            end
        end
        if (row_cmd[r] == EXECUTE) begin
            run_execute(r);
        end

        while (push_col_q.size() - push_base < row_pushes[r] ||
               act_q.size() - act_base < row_acts[r] ||
               reply_q.size() - reply_base < row_reply_len[r]) begin
            @(negedge clk);
        end
        // Quiet period catches extra pulses or reply bytes
        repeat (SETTLE) @(negedge clk);

        check_byte("wf_push count", byte_t'(row_pushes[r]),
                   byte_t'(push_col_q.size() - push_base));
        check_byte("init_act_valid count", byte_t'(row_acts[r]), byte_t'(act_q.size() - act_base));
        check_byte("uart_tx byte count", byte_t'(row_reply_len[r]),
                   byte_t'(reply_q.size() - reply_base));
        check_byte("wf_reset count", byte_t'(row_pushes[r] > 0),
                   byte_t'(wf_reset_cnt - reset_base));
        check_byte("start_mlp rise count", byte_t'(row_cmd[r] == EXECUTE),
                   byte_t'(start_rise_cnt - start_base));

        // Columns alternate col0 and col1 with data in arrival order
        for (int k = 0; k < row_pushes[r]; k++) begin
            check_flag("wf_push_col1", (k % 2) == 1, push_col_q[push_base + k]);
            check_byte("wf_data_in", row_data[r][k], push_data_q[push_base + k]);
        end
        if (row_pushes[r] > 0) begin
            check_flag("weights_ready", 1'b1, weights_ready);
        end
        if (row_acts[r] > 0) begin
            check_act("init_act_data", {row_data[r][2], row_data[r][0]}, act_q[act_base]);
            check_act("init_act_data", {row_data[r][3], row_data[r][1]}, act_q[act_base + 1]);
        end

        sel_acc = (row_cmd[r] == READ_ACC1) ? row_acc1[r] : row_acc0[r];
        for (int k = 0; k < row_reply_len[r]; k++) begin
            if (row_cmd[r] == STATUS) begin
                exp_b = {row_state[r], row_cnt[r][3:0]};
            end else begin
                exp_b = sel_acc[8*k +: 8];
            end
            check_byte("uart_tx byte", exp_b, reply_q[reply_base + k]);
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (wf_reset) begin
                wf_reset_cnt++;
            end
            if (wf_push_col0 || wf_push_col1) begin
                push_col_q.push_back(wf_push_col1);
                push_data_q.push_back(wf_data_in);
            end
            if (init_act_valid) begin
                act_q.push_back(init_act_data);
            end
            if (start_mlp && !start_prev) begin
                start_rise_cnt++;
            end
            start_prev = start_mlp;
        end
    end

    // A bound assertion failure ends the run at once
    always @(negedge clk) begin
        if (tpu_uart_ctrl_i.tpu_uart_ctrl_sva_i.assert_fail_cnt != 0) begin
            $display("A bound assertion on the DUT failed");
            fail_run();
        end
    end

    initial begin
        byte_t b;
        wait (rst === 1'b0);
        forever begin
            receive_serial_byte(b);
            reply_q.push_back(b);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Run timed out after %0d ns before all rows finished", WATCHDOG_NS);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst           = 1'b1;
        uart_rx       = 1'b1;
        mlp_state     = MLP_IDLE;
        mlp_cycle_cnt = '0;
        mlp_acc0      = '0;
        mlp_acc1      = '0;
        seed          = 32'hf037;

        fill_row(0, WRITE_WEIGHT, 4'h0, 4, 0, 0);
        fill_row(1, WRITE_ACT,    4'h0, 0, 2, 0);
        fill_row(2, EXECUTE,      4'h6, 0, 0, 0);
        fill_row(3, READ_ACC0,    4'h6, 0, 0, `TPU_ACC_BYTES);
        fill_row(4, READ_ACC1,    4'h6, 0, 0, `TPU_ACC_BYTES);
        fill_row(5, STATUS,       4'h6, 0, 0, 1);
        fill_row(6, 8'h7f,        4'h2, 0, 0, 0);
        fill_row(7, STATUS,       4'hb, 0, 0, 1);

        repeat (4) @(negedge clk);
        rst = 1'b0;

        check_flag("wf_reset", 1'b0, wf_reset);
        check_flag("wf_push_col0", 1'b0, wf_push_col0);
        check_flag("wf_push_col1", 1'b0, wf_push_col1);
        check_flag("init_act_valid", 1'b0, init_act_valid);
        check_flag("start_mlp", 1'b0, start_mlp);
        check_flag("weights_ready", 1'b0, weights_ready);
        check_flag("uart_tx", 1'b1, uart_tx);

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        if (tpu_uart_ctrl_i.tpu_uart_ctrl_sva_i.assert_fail_cnt == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("%0d assertion failures were reported during the run",
                     tpu_uart_ctrl_i.tpu_uart_ctrl_sva_i.assert_fail_cnt);
            $display("Test failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// ==== dv/tpu_uart_ctrl_sva.sv ====
`timescale 1ns/1ps

module tpu_uart_ctrl_sva import tpu_cmd_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       uart_tx,
    input logic       wf_push_col0,
    input logic       wf_push_col1,
    input logic       wf_reset,
    input logic       start_mlp,
    input mlp_state_t mlp_state
);

    int assert_fail_cnt = 0;

    // One weight column per cycle
    one_push_at_a_time: assert property (@(posedge clk) disable iff (rst)
        !(wf_push_col0 && wf_push_col1))
        else begin
            assert_fail_cnt++;
            $error("wf_push_col0 and wf_push_col1 high in the same cycle");
        end

    // FIFO reset leads straight into the first col0 push
    reset_then_col0: assert property (@(posedge clk) disable iff (rst)
        wf_reset |=> wf_push_col0)
        else begin
            assert_fail_cnt++;
            $error("wf_reset was not followed by wf_push_col0");
        end

    start_drops_when_busy: assert property (@(posedge clk) disable iff (rst)
        $fell(start_mlp) |-> (mlp_state != MLP_IDLE))
        else begin
            assert_fail_cnt++;
            $error("start_mlp fell while mlp_state was idle");
        end

    // Line idles high from the second reset cycle on
    tx_idle_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> uart_tx)
        else begin
            assert_fail_cnt++;
            $error("uart_tx low during reset");
        end

endmodule

bind tpu_uart_ctrl tpu_uart_ctrl_sva tpu_uart_ctrl_sva_i (
    .clk          (clk),
    .rst          (rst),
    .uart_tx      (uart_tx),
    .wf_push_col0 (wf_push_col0),
    .wf_push_col1 (wf_push_col1),
    .wf_reset     (wf_reset),
    .start_mlp    (start_mlp),
    .mlp_state    (mlp_state)
);

// ==== source/tpu_uart_ctrl.sv ====
`timescale 1ns/1ps

`include "tpu_link_params.svh"

module tpu_uart_ctrl import uart_pkg::*, tpu_cmd_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       uart_rx,
    output logic       uart_tx,
    output logic       wf_push_col0,
    output logic       wf_push_col1,
    output byte_t      wf_data_in,
    output logic       wf_reset,
    output logic       init_act_valid,
    output act_word_t  init_act_data,
    output logic       start_mlp,
    output logic       weights_ready,
    input  mlp_state_t mlp_state,
    input  cycle_cnt_t mlp_cycle_cnt,
    input  acc_t       mlp_acc0,
    input  acc_t       mlp_acc1
);

    byte_t rx_data;
    logic  rx_valid;
    byte_t tx_data;
    logic  tx_valid;
    logic  tx_ready;
    logic  weight_load;
    logic  act_load;
    logic  exec;
    logic  read_acc0;
    logic  read_acc1;
    logic  read_status;
    logic  resp_busy;
    byte_t data_bytes [`TPU_DATA_BYTES];

    uart_rx uart_rx_i (
        .clk      (clk),
        .rst      (rst),
        .rx       (uart_rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    cmd_decoder cmd_decoder_i (
        .clk         (clk),
        .rst         (rst),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .resp_busy   (resp_busy),
        .weight_load (weight_load),
        .act_load    (act_load),
        .exec        (exec),
        .read_acc0   (read_acc0),
        .read_acc1   (read_acc1),
        .read_status (read_status),
        .data_bytes  (data_bytes)
    );

    mlp_loader mlp_loader_i (
        .clk            (clk),
        .rst            (rst),
        .weight_load    (weight_load),
        .act_load       (act_load),
        .exec           (exec),
        .data_bytes     (data_bytes),
        .mlp_state      (mlp_state),
        .wf_reset       (wf_reset),
        .wf_push_col0   (wf_push_col0),
        .wf_push_col1   (wf_push_col1),
        .wf_data_in     (wf_data_in),
        .init_act_valid (init_act_valid),
        .init_act_data  (init_act_data),
        .start_mlp      (start_mlp),
        .weights_ready  (weights_ready)
    );

    resp_serializer resp_serializer_i (
        .clk           (clk),
        .rst           (rst),
        .read_acc0     (read_acc0),
        .read_acc1     (read_acc1),
        .read_status   (read_status),
        .mlp_acc0      (mlp_acc0),
        .mlp_acc1      (mlp_acc1),
        .mlp_state     (mlp_state),
        .mlp_cycle_cnt (mlp_cycle_cnt),
        .tx_ready      (tx_ready),
        .tx_data       (tx_data),
        .tx_valid      (tx_valid),
        .resp_busy     (resp_busy)
    );

    uart_tx uart_tx_i (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx       (uart_tx),
        .tx_ready (tx_ready)
    );

endmodule

// ==== source/resp_serializer.sv ====
`timescale 1ns/1ps

`include "tpu_link_params.svh"

module resp_serializer import uart_pkg::*, tpu_cmd_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       read_acc0,
    input  logic       read_acc1,
    input  logic       read_status,
    input  acc_t       mlp_acc0,
    input  acc_t       mlp_acc1,
    input  mlp_state_t mlp_state,
    input  cycle_cnt_t mlp_cycle_cnt,
    input  logic       tx_ready,
    output byte_t      tx_data,
    output logic       tx_valid,
    output logic       resp_busy
);

    localparam int IDX_W = $clog2(`TPU_ACC_BYTES);

    typedef enum logic [1:0] {S_IDLE, S_OFFER, S_DRAIN} ser_state_t;

    ser_state_t       state;
    byte_t            resp_buf [`TPU_ACC_BYTES];
    logic [IDX_W-1:0] resp_idx;
    logic [IDX_W:0]   resp_len;

    assign tx_data = resp_buf[resp_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            resp_idx  <= '0;
            resp_len  <= '0;
            tx_valid  <= 1'b0;
            resp_busy <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    resp_idx <= '0;
                    if (read_acc0 || read_acc1 || read_status) begin
                        resp_len  <= read_status ? (IDX_W+1)'(1) : (IDX_W+1)'(`TPU_ACC_BYTES);
                        resp_busy <= 1'b1;
                        state     <= S_OFFER;
                    end
                end
                S_OFFER: begin
                    // Offer once, drop valid when the transmitter goes busy
                    if (!tx_valid && tx_ready) begin
                        tx_valid <= 1'b1;
                    end else if (tx_valid && !tx_ready) begin
                        tx_valid <= 1'b0;
                        state    <= S_DRAIN;
                    end
                end
                S_DRAIN: begin
                    // Wait for the stop bit to finish
                    if (tx_ready) begin
                        if ({1'b0, resp_idx} == resp_len - 1'b1) begin
                            resp_busy <= 1'b0;
                            state     <= S_IDLE;
                        end else begin
                            resp_idx <= resp_idx + 1'b1;
                            state    <= S_OFFER;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Snapshot taken at the read strobe, LSB first
    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            if (read_acc0 || read_acc1) begin
                for (int i = 0; i < `TPU_ACC_BYTES; i++) begin
                    resp_buf[i] <= read_acc1 ? mlp_acc1[8*i +: 8] : mlp_acc0[8*i +: 8];
                end
            end else if (read_status) begin
                resp_buf[0] <= {mlp_state, mlp_cycle_cnt[3:0]};
            end
        end
    end

endmodule

// ==== source/mlp_loader.sv ====
`timescale 1ns/1ps

`include "tpu_link_params.svh"

module mlp_loader import uart_pkg::*, tpu_cmd_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       weight_load,
    input  logic       act_load,
    input  logic       exec,
    input  byte_t      data_bytes [`TPU_DATA_BYTES],
    input  mlp_state_t mlp_state,
    output logic       wf_reset,
    output logic       wf_push_col0,
    output logic       wf_push_col1,
    output byte_t      wf_data_in,
    output logic       init_act_valid,
    output act_word_t  init_act_data,
    output logic       start_mlp,
    output logic       weights_ready
);

    localparam int STEP_W = $clog2(`TPU_DATA_BYTES);

    logic              w_active;
    logic [STEP_W-1:0] w_step;
    logic              act_second;
    mlp_state_t        mlp_state_prev;

    always_ff @(posedge clk) begin
        if (rst) begin
            w_active       <= 1'b0;
            w_step         <= '0;
            act_second     <= 1'b0;
            mlp_state_prev <= MLP_IDLE;
            wf_reset       <= 1'b0;
            wf_push_col0   <= 1'b0;
            wf_push_col1   <= 1'b0;
            init_act_valid <= 1'b0;
            start_mlp      <= 1'b0;
            weights_ready  <= 1'b0;
        end else begin
            wf_reset       <= 1'b0;
            wf_push_col0   <= 1'b0;
            wf_push_col1   <= 1'b0;
            init_act_valid <= 1'b0;
            mlp_state_prev <= mlp_state;

            // MLP has left idle, so it took the start request
            if (start_mlp && mlp_state_prev == MLP_IDLE && mlp_state != MLP_IDLE) begin
                start_mlp     <= 1'b0;
                weights_ready <= 1'b0;
            end
            if (exec) begin
                start_mlp <= 1'b1;
            end

            // FIFO reset first, then alternate col0 and col1
            if (weight_load) begin
                wf_reset <= 1'b1;
                w_active <= 1'b1;
                w_step   <= '0;
            end else if (w_active) begin
                wf_push_col0 <= !w_step[0];
                wf_push_col1 <= w_step[0];
                w_step       <= w_step + 1'b1;
                if (w_step == STEP_W'(`TPU_DATA_BYTES - 1)) begin
                    w_active      <= 1'b0;
                    weights_ready <= 1'b1;
                end
            end

            init_act_valid <= act_load || act_second;
            act_second     <= act_load;
        end
    end

    // Column order: {A10,A00} then {A11,A01}
    always_ff @(posedge clk) begin
        if (w_active) begin
            wf_data_in <= data_bytes[w_step];
        end
        if (act_load) begin
            init_act_data <= {data_bytes[2], data_bytes[0]};
        end else if (act_second) begin
            init_act_data <= {data_bytes[3], data_bytes[1]};
        end
    end

endmodule

// ==== source/cmd_decoder.sv ====
`timescale 1ns/1ps

`include "tpu_link_params.svh"

module cmd_decoder import uart_pkg::*, tpu_cmd_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  byte_t rx_data,
    input  logic  rx_valid,
    input  logic  resp_busy,
    output logic  weight_load,
    output logic  act_load,
    output logic  exec,
    output logic  read_acc0,
    output logic  read_acc1,
    output logic  read_status,
    output byte_t data_bytes [`TPU_DATA_BYTES]
);

    localparam int CNT_W = $clog2(`TPU_DATA_BYTES);

    typedef enum logic [1:0] {D_CMD, D_DATA, D_WAIT} dec_state_t;

    dec_state_t       state;
    cmd_t             cmd_reg;
    logic [CNT_W-1:0] byte_cnt;
    logic             read_issued;

    // Serializer raises busy one cycle after the read strobe
    assign read_issued = read_acc0 || read_acc1 || read_status;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= D_CMD;
            cmd_reg     <= WRITE_WEIGHT;
            byte_cnt    <= '0;
            weight_load <= 1'b0;
            act_load    <= 1'b0;
            exec        <= 1'b0;
            read_acc0   <= 1'b0;
            read_acc1   <= 1'b0;
            read_status <= 1'b0;
        end else begin
            weight_load <= 1'b0;
            act_load    <= 1'b0;
            exec        <= 1'b0;
            read_acc0   <= 1'b0;
            read_acc1   <= 1'b0;
            read_status <= 1'b0;
            case (state)
                D_CMD: begin
                    if (rx_valid) begin
                        cmd_reg  <= cmd_t'(rx_data);
                        byte_cnt <= '0;
                        case (cmd_t'(rx_data))
                            WRITE_WEIGHT, WRITE_ACT: state <= D_DATA;
                            EXECUTE: exec <= 1'b1;
                            READ_ACC0: begin
                                read_acc0 <= 1'b1;
                                state     <= D_WAIT;
                            end
                            READ_ACC1: begin
                                read_acc1 <= 1'b1;
                                state     <= D_WAIT;
                            end
                            STATUS: begin
                                read_status <= 1'b1;
                                state       <= D_WAIT;
                            end
                            // Unknown codes are dropped
                            default: ;
                        endcase
                    end
                end
                D_DATA: begin
                    if (rx_valid) begin
                        if (byte_cnt == CNT_W'(`TPU_DATA_BYTES - 1)) begin
                            weight_load <= (cmd_reg == WRITE_WEIGHT);
                            act_load    <= (cmd_reg == WRITE_ACT);
                            state       <= D_CMD;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                D_WAIT: begin
                    // Incoming bytes are ignored until the reply is out
                    if (!resp_busy && !read_issued) begin
                        state <= D_CMD;
                    end
                end
                default: state <= D_CMD;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == D_DATA && rx_valid) begin
            data_bytes[byte_cnt] <= rx_data;
        end
    end

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/1ps

`include "tpu_link_params.svh"

module uart_tx import uart_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  byte_t tx_data,
    input  logic  tx_valid,
    output logic  tx,
    output logic  tx_ready
);

    localparam int CLKS  = `TPU_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);

    logic             busy;
    logic [9:0]       frame;
    logic [3:0]       bit_idx;
    logic [CNT_W-1:0] clk_cnt;

    assign tx_ready = !busy;
    assign tx       = frame[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            frame   <= '1;
            bit_idx <= '0;
            clk_cnt <= '0;
        end else if (!busy) begin
            if (tx_valid) begin
                // Stop bit, data LSB first, start bit
                frame   <= {1'b1, tx_data, 1'b0};
                busy    <= 1'b1;
                bit_idx <= '0;
                clk_cnt <= '0;
            end
        end else if (clk_cnt == CNT_W'(CLKS - 1)) begin
            clk_cnt <= '0;
            // Shift in ones so the line rests high
            frame   <= {1'b1, frame[9:1]};
            if (bit_idx == 4'd9) begin
                busy <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

// ==== source/uart_rx.sv ====
`timescale 1ns/1ps

`include "tpu_link_params.svh"

module uart_rx import uart_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  rx,
    output byte_t rx_data,
    output logic  rx_valid
);

    localparam int CLKS  = `TPU_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_sync;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic             bit_tick;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // One full bit period has passed since the last sample point
    assign bit_tick = (clk_cnt == CNT_W'(CLKS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Recheck at mid start bit to reject glitches
                    if (clk_cnt == CNT_W'(CLKS / 2 - 1)) begin
                        clk_cnt <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_tick) begin
                        // Framing error drops the byte
                        rx_valid <= rx_sync;
                        state    <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_tick) begin
            rx_data <= {rx_sync, rx_data[7:1]};
        end
    end

endmodule

// ==== source/tpu_cmd_pkg.sv ====
package tpu_cmd_pkg;

    // Host command codes
    typedef enum logic [7:0] {
        WRITE_WEIGHT = 8'h01,
        WRITE_ACT    = 8'h02,
        EXECUTE      = 8'h03,
        READ_ACC0    = 8'h04,
        STATUS       = 8'h05,
        READ_ACC1    = 8'h06
    } cmd_t;

    // MLP status as seen from the front end
    typedef logic [3:0] mlp_state_t;
    typedef logic [4:0] cycle_cnt_t;

    localparam mlp_state_t MLP_IDLE = 4'd0;

    typedef logic signed [31:0] acc_t;

    // Activation column word, row 1 in the high byte
    typedef logic [15:0] act_word_t;

endpackage

// ==== source/uart_pkg.sv ====
package uart_pkg;

    // One serial payload byte
    typedef logic [7:0] byte_t;

endpackage

// ==== source/tpu_link_params.svh ====
`ifndef TPU_LINK_PARAMS_SVH
`define TPU_LINK_PARAMS_SVH

// Serial bit period in clock cycles
// For hardware use clock frequency divided by baud rate,
// e.g. 100 MHz / 115200 gives 868
`define TPU_CLKS_PER_BIT 16

// Frame lengths in bytes
// Data bytes that follow a write command
`define TPU_DATA_BYTES 4
// Bytes returned for one accumulator read
`define TPU_ACC_BYTES 4

`endif
